// ==== src/regmap_pkg.sv ====
package regmap_pkg;

    // Host bus widths
    localparam int host_addr_w = 6;
    localparam int host_data_w = 32;

    // ========================================
    // Register word indices
    // ========================================
    localparam logic [3:0] reg_control       = 4'd0;
    localparam logic [3:0] reg_status        = 4'd1;
    localparam logic [3:0] reg_audio_base    = 4'd2;
    localparam logic [3:0] reg_motion_base   = 4'd3;
    localparam logic [3:0] reg_audio_result  = 4'd4;
    localparam logic [3:0] reg_motion_result = 4'd5;
    localparam logic [3:0] reg_mem_addr      = 4'd6;
    localparam logic [3:0] reg_mem_wdata     = 4'd7;

    // Enable bits in control, done bits in status
    localparam int bit_audio  = 0;
    localparam int bit_motion = 1;

endpackage

// ==== src/sample_pkg.sv ====
package sample_pkg;

    localparam int word_w     = 32;
    localparam int ram_addr_w = 10;

    typedef logic [word_w-1:0]     mem_word_t;
    typedef logic [ram_addr_w-1:0] ram_addr_t;
    typedef logic [31:0]           result_t;

    // Audio word, signed sample in the low half
    typedef struct packed {
        logic [15:0]        pad;
        logic signed [15:0] value;
    } audio_sample_t;

    // Motion word, y above x
    typedef struct packed {
        logic signed [15:0] y;
        logic signed [15:0] x;
    } motion_sample_t;

    // Magnitude of a signed 16-bit value, 17 bits so -32768 fits
    function automatic logic [16:0] abs16(logic signed [15:0] v);
        logic signed [16:0] wide;
        wide = v;
        return v[15] ? 17'(-wide) : 17'(wide);
    endfunction

endpackage

// ==== src/mem_port_if.sv ====
`timescale 1ns/1ps

interface mem_port_if;
    import sample_pkg::*;

    logic      req;
    ram_addr_t addr;
    mem_word_t rdata;
    // One-cycle strobe, rdata valid with it
    logic      ready;

    modport fetcher (output req, output addr, input rdata, input ready);
    modport arbiter (input req, input addr, output rdata, output ready);

endinterface

// ==== src/host_regs.sv ====
`timescale 1ns/1ps

module host_regs (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [regmap_pkg::host_addr_w-1:0] s_axi_araddr,
    input  logic                               s_axi_arvalid,
    output logic                               s_axi_arready,
    output logic [regmap_pkg::host_data_w-1:0] s_axi_rdata,
    output logic                               s_axi_rvalid,
    input  logic                               s_axi_rready,
    input  logic [regmap_pkg::host_addr_w-1:0] s_axi_awaddr,
    input  logic                               s_axi_awvalid,
    output logic                               s_axi_awready,
    input  logic [regmap_pkg::host_data_w-1:0] s_axi_wdata,
    input  logic                               s_axi_wvalid,
    output logic                               s_axi_wready,
    output logic                               s_axi_bvalid,
    input  logic                               s_axi_bready,
    output logic                               audio_enable,
    output logic                               motion_enable,
    output sample_pkg::ram_addr_t              audio_base,
    output sample_pkg::ram_addr_t              motion_base,
    output logic                               host_wr,
    output sample_pkg::ram_addr_t              host_wr_addr,
    output sample_pkg::mem_word_t              host_wr_data,
    input  logic                               audio_done,
    input  logic                               motion_done,
    input  sample_pkg::result_t                audio_result,
    input  sample_pkg::result_t                motion_result
);
    import regmap_pkg::*;
    import sample_pkg::*;

    logic [host_data_w-1:0] control_q;
    logic [host_data_w-1:0] audio_base_q;
    logic [host_data_w-1:0] motion_base_q;
    logic [host_data_w-1:0] mem_addr_q;
    logic [host_data_w-1:0] status;
    logic [host_data_w-1:0] rd_word;
    logic [3:0]             rd_idx;
    logic [3:0]             wr_idx;
    logic                   wr_accept_q;
    logic                   rd_hs;
    logic                   wr_hs;

    assign rd_idx = s_axi_araddr[host_addr_w-1:2];
    assign wr_idx = s_axi_awaddr[host_addr_w-1:2];
    assign rd_hs  = s_axi_arready && s_axi_arvalid;
    assign wr_hs  = wr_accept_q && s_axi_awvalid && s_axi_wvalid;

    // Address and data are taken in the same cycle
    assign s_axi_awready = wr_accept_q;
    assign s_axi_wready  = wr_accept_q;

    // ========================================
    // Read channel
    // ========================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s_axi_arready <= 1'b0;
            s_axi_rvalid  <= 1'b0;
        end else begin
            s_axi_arready <= !s_axi_arready && s_axi_arvalid && !s_axi_rvalid;
            if (rd_hs) begin
                s_axi_rvalid <= 1'b1;
            end else if (s_axi_rready) begin
                s_axi_rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_hs) begin
            s_axi_rdata <= rd_word;
        end
    end

    always_comb begin
        status             = '0;
        status[bit_audio]  = audio_done;
        status[bit_motion] = motion_done;
        case (rd_idx)
            reg_control:       rd_word = control_q;
            reg_status:        rd_word = status;
            reg_audio_base:    rd_word = audio_base_q;
            reg_motion_base:   rd_word = motion_base_q;
            reg_audio_result:  rd_word = audio_result;
            reg_motion_result: rd_word = motion_result;
            reg_mem_addr:      rd_word = mem_addr_q;
            default:           rd_word = '0;
        endcase
    end

    // ========================================
    // Write channel and register file
    // ========================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_accept_q   <= 1'b0;
            s_axi_bvalid  <= 1'b0;
            host_wr       <= 1'b0;
            control_q     <= '0;
            audio_base_q  <= '0;
            motion_base_q <= '0;
            mem_addr_q    <= '0;
        end else begin
            wr_accept_q <= !wr_accept_q && s_axi_awvalid && s_axi_wvalid && !s_axi_bvalid;
            if (wr_hs) begin
                s_axi_bvalid <= 1'b1;
            end else if (s_axi_bready) begin
                s_axi_bvalid <= 1'b0;
            end
            host_wr <= wr_hs && (wr_idx == reg_mem_wdata);
            if (wr_hs) begin
                case (wr_idx)
                    reg_control:     control_q     <= s_axi_wdata;
                    reg_audio_base:  audio_base_q  <= s_axi_wdata;
                    reg_motion_base: motion_base_q <= s_axi_wdata;
                    reg_mem_addr:    mem_addr_q    <= s_axi_wdata;
                    default: ;
                endcase
            end
        end
    end

    // RAM load word, written one cycle after the handshake
    always_ff @(posedge clk) begin
        if (wr_hs) begin
            host_wr_data <= s_axi_wdata;
        end
    end

    assign audio_enable  = control_q[bit_audio];
    assign motion_enable = control_q[bit_motion];
    // Bases are byte addresses, mem_addr is a word address
    assign audio_base    = audio_base_q[ram_addr_w+1:2];
    assign motion_base   = motion_base_q[ram_addr_w+1:2];
    assign host_wr_addr  = ram_addr_t'(mem_addr_q);

endmodule

// ==== src/sample_fetcher.sv ====
`timescale 1ns/1ps

module sample_fetcher #(
    parameter type sample_t    = sample_pkg::audio_sample_t,
    parameter int  num_samples = 16
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  enable,
    input  sample_pkg::ram_addr_t base,
    mem_port_if.fetcher           mem,
    output logic                  start,
    output logic                  sample_valid,
    output sample_t               sample,
    output logic                  done
);
    import sample_pkg::*;

    localparam int cnt_w = $clog2(num_samples + 1);

    typedef enum logic [1:0] {
        st_idle,
        st_read,
        st_done
    } state_t;

    state_t           state_q;
    ram_addr_t        addr_q;
    logic [cnt_w-1:0] count_q;
    logic             last;

    assign start        = (state_q == st_idle) && enable;
    assign mem.req      = (state_q == st_read);
    assign mem.addr     = addr_q;
    assign sample_valid = mem.ready && (state_q == st_read);
    assign sample       = sample_t'(mem.rdata);
    assign done         = (state_q == st_done);
    assign last         = (count_q == cnt_w'(num_samples - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= st_idle;
            addr_q  <= '0;
            count_q <= '0;
        end else begin
            case (state_q)
                st_idle: begin
                    if (enable) begin
                        state_q <= st_read;
                        addr_q  <= base;
                        count_q <= '0;
                    end
                end
                st_read: begin
                    // Address steps only after the word came back
                    if (mem.ready) begin
                        addr_q  <= addr_q + 1'b1;
                        count_q <= count_q + 1'b1;
                        if (last) begin
                            state_q <= st_done;
                        end
                    end
                end
                st_done: begin
                    if (!enable) begin
                        state_q <= st_idle;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

endmodule

// ==== src/audio_level_meter.sv ====
`timescale 1ns/1ps

module audio_level_meter (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  logic                      sample_valid,
    input  sample_pkg::audio_sample_t sample,
    output sample_pkg::result_t       result
);
    import sample_pkg::*;

    logic [16:0] magnitude;

    assign magnitude = abs16(sample.value);

    // Running sum of magnitudes
    always_ff @(posedge clk) begin
        if (!rst_n || start) begin
            result <= '0;
        end else if (sample_valid) begin
            result <= result + 32'(magnitude);
        end
    end

endmodule

// ==== src/motion_peak_detector.sv ====
`timescale 1ns/1ps

module motion_peak_detector (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start,
    input  logic                       sample_valid,
    input  sample_pkg::motion_sample_t sample,
    output sample_pkg::result_t        result
);
    import sample_pkg::*;

    logic [17:0] manhattan;
    result_t     candidate;

    // |x| + |y|, 18 bits for the worst case
    assign manhattan = 18'(abs16(sample.x)) + 18'(abs16(sample.y));
    assign candidate = 32'(manhattan);

    always_ff @(posedge clk) begin
        if (!rst_n || start) begin
            result <= '0;
        end else if (sample_valid && (candidate > result)) begin
            result <= candidate;
        end
    end

endmodule

// ==== src/mem_arbiter_ram.sv ====
`timescale 1ns/1ps

module mem_arbiter_ram (
    input  logic                  clk,
    input  logic                  rst_n,
    mem_port_if.arbiter           audio_port,
    mem_port_if.arbiter           motion_port,
    input  logic                  host_wr,
    input  sample_pkg::ram_addr_t host_wr_addr,
    input  sample_pkg::mem_word_t host_wr_data
);
    import sample_pkg::*;

    localparam logic grant_audio  = 1'b0;
    localparam logic grant_motion = 1'b1;

    logic      grant_q;
    logic      pending_q;
    logic      gnt_req;
    ram_addr_t gnt_addr;
    logic      rd_issue;
    mem_word_t ram [2**ram_addr_w];
    mem_word_t rd_data_q;

    // ========================================
    // Grant and read issue
    // ========================================
    assign gnt_req  = (grant_q == grant_motion) ? motion_port.req : audio_port.req;
    assign gnt_addr = (grant_q == grant_motion) ? motion_port.addr : audio_port.addr;
    // Host write owns the port this cycle
    assign rd_issue = gnt_req && !pending_q && !host_wr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            grant_q   <= grant_audio;
            pending_q <= 1'b0;
        end else begin
            if (!gnt_req) begin
                grant_q <= ~grant_q;
            end
            pending_q <= rd_issue;
        end
    end

    // ========================================
    // Block RAM
    // ========================================
    always_ff @(posedge clk) begin
        if (host_wr) begin
            ram[host_wr_addr] <= host_wr_data;
        end
        if (rd_issue) begin
            rd_data_q <= ram[gnt_addr];
        end
    end

    assign audio_port.rdata  = rd_data_q;
    assign motion_port.rdata = rd_data_q;
    assign audio_port.ready  = pending_q && (grant_q == grant_audio);
    assign motion_port.ready = pending_q && (grant_q == grant_motion);

endmodule

// ==== src/sensor_accel_top.sv ====
`timescale 1ns/1ps

module sensor_accel_top #(
    parameter int audio_samples  = 16,
    parameter int motion_samples = 8
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [regmap_pkg::host_addr_w-1:0] s_axi_araddr,
    input  logic                               s_axi_arvalid,
    output logic                               s_axi_arready,
    output logic [regmap_pkg::host_data_w-1:0] s_axi_rdata,
    output logic                               s_axi_rvalid,
    input  logic                               s_axi_rready,
    input  logic [regmap_pkg::host_addr_w-1:0] s_axi_awaddr,
    input  logic                               s_axi_awvalid,
    output logic                               s_axi_awready,
    input  logic [regmap_pkg::host_data_w-1:0] s_axi_wdata,
    input  logic                               s_axi_wvalid,
    output logic                               s_axi_wready,
    output logic                               s_axi_bvalid,
    input  logic                               s_axi_bready,
    output logic                               irq
);
    import sample_pkg::*;

    logic           audio_enable;
    logic           motion_enable;
    ram_addr_t      audio_base;
    ram_addr_t      motion_base;
    logic           host_wr;
    ram_addr_t      host_wr_addr;
    mem_word_t      host_wr_data;
    logic           audio_start;
    logic           audio_valid;
    audio_sample_t  audio_sample;
    logic           audio_done;
    result_t        audio_result;
    logic           motion_start;
    logic           motion_valid;
    motion_sample_t motion_sample;
    logic           motion_done;
    result_t        motion_result;

    mem_port_if audio_mem ();
    mem_port_if motion_mem ();

    assign irq = audio_done | motion_done;

    host_regs u_regs (
        .clk, .rst_n,
        .s_axi_araddr, .s_axi_arvalid, .s_axi_arready, .s_axi_rdata, .s_axi_rvalid,
        .s_axi_rready, .s_axi_awaddr, .s_axi_awvalid, .s_axi_awready, .s_axi_wdata,
        .s_axi_wvalid, .s_axi_wready, .s_axi_bvalid, .s_axi_bready,
        .audio_enable, .motion_enable, .audio_base, .motion_base,
        .host_wr, .host_wr_addr, .host_wr_data,
        .audio_done, .motion_done, .audio_result, .motion_result
    );

    // Audio path
    sample_fetcher #(.sample_t(audio_sample_t), .num_samples(audio_samples)) audio_fetch (
        .clk, .rst_n, .enable(audio_enable), .base(audio_base), .mem(audio_mem.fetcher),
        .start(audio_start), .sample_valid(audio_valid), .sample(audio_sample),
        .done(audio_done)
    );

    audio_level_meter u_level (
        .clk, .rst_n, .start(audio_start), .sample_valid(audio_valid),
        .sample(audio_sample), .result(audio_result)
    );

    // Motion path
    sample_fetcher #(.sample_t(motion_sample_t), .num_samples(motion_samples)) motion_fetch (
        .clk, .rst_n, .enable(motion_enable), .base(motion_base), .mem(motion_mem.fetcher),
        .start(motion_start), .sample_valid(motion_valid), .sample(motion_sample),
        .done(motion_done)
    );

    motion_peak_detector u_peak (
        .clk, .rst_n, .start(motion_start), .sample_valid(motion_valid),
        .sample(motion_sample), .result(motion_result)
    );

    mem_arbiter_ram u_mem (
        .clk, .rst_n, .audio_port(audio_mem.arbiter), .motion_port(motion_mem.arbiter),
        .host_wr, .host_wr_addr, .host_wr_data
    );

endmodule

// ==== tb/sensor_accel_assertions.sv ====
`timescale 1ns/1ps

module sensor_accel_assertions (
    input logic clk,
    input logic rst_n,
    input logic grant,
    input logic gnt_req,
    input logic rd_issue,
    input logic audio_req,
    input logic motion_req,
    input logic audio_ready,
    input logic motion_ready
);
    logic any_ready;

    assign any_ready = audio_ready || motion_ready;

    // ready returns to the port whose read went out a cycle earlier
    // Grant low selects audio
    audio_ready_after_issue: assert property (@(posedge clk) disable iff (!rst_n)
        audio_ready |-> $past(rd_issue && audio_req && !grant))
        else $error("audio ready without a read issued for the audio port");

    motion_ready_after_issue: assert property (@(posedge clk) disable iff (!rst_n)
        motion_ready |-> $past(rd_issue && motion_req && grant))
        else $error("motion ready without a read issued for the motion port");

    grant_held: assert property (@(posedge clk) disable iff (!rst_n)
        gnt_req |=> $stable(grant))
        else $error("grant moved while the granted req was high");

    no_back_to_back: assert property (@(posedge clk) disable iff (!rst_n)
        any_ready |=> !any_ready)
        else $error("ready on two consecutive cycles");

endmodule

bind mem_arbiter_ram sensor_accel_assertions u_arb_assert (
    .clk, .rst_n, .grant(grant_q), .gnt_req, .rd_issue,
    .audio_req(audio_port.req), .motion_req(motion_port.req),
    .audio_ready(audio_port.ready), .motion_ready(motion_port.ready)
);

// ==== tb/tb_sensor_accel.sv ====
`timescale 1ns/1ps

module tb_sensor_accel;
    import regmap_pkg::*;
    import sample_pkg::*;

    localparam int audio_samples   = 16;
    localparam int motion_samples  = 8;
    localparam int load_words      = 64;
    localparam int num_tests       = 5;
    localparam int worst_burst     = (audio_samples > motion_samples) ? audio_samples
                                                                       : motion_samples;
    localparam int watchdog_cycles = num_tests * worst_burst * 40 + load_words * 20;
    // Word offset of the second region in the rerun test
    localparam int rerun_offset    = 12;

    typedef enum int {k_regs, k_run, k_rerun} kind_t;

    typedef struct {
        string      name;
        int         audio_base;
        int         motion_base;
        logic [1:0] mask;
        kind_t      kind;
    } test_row_t;

    logic                   clk;
    logic                   rst_n;
    logic [host_addr_w-1:0] s_axi_araddr;
    logic                   s_axi_arvalid;
    logic                   s_axi_arready;
    logic [host_data_w-1:0] s_axi_rdata;
    logic                   s_axi_rvalid;
    logic                   s_axi_rready;
    logic [host_addr_w-1:0] s_axi_awaddr;
    logic                   s_axi_awvalid;
    logic                   s_axi_awready;
    logic [host_data_w-1:0] s_axi_wdata;
    logic                   s_axi_wvalid;
    logic                   s_axi_wready;
    logic                   s_axi_bvalid;
    logic                   s_axi_bready;
    logic                   irq;

    mem_word_t ram_model [load_words];
    test_row_t tests [num_tests];
    int        errors;
    int        failed_tests;
    string     current_test;

    sensor_accel_top #(
        .audio_samples(audio_samples),
        .motion_samples(motion_samples)
    ) DUT (
        .clk, .rst_n,
        .s_axi_araddr, .s_axi_arvalid, .s_axi_arready, .s_axi_rdata, .s_axi_rvalid,
        .s_axi_rready, .s_axi_awaddr, .s_axi_awvalid, .s_axi_awready, .s_axi_wdata,
        .s_axi_wvalid, .s_axi_wready, .s_axi_bvalid, .s_axi_bready, .irq
    );

    always #2 clk = ~clk;

    // ========================================
    // Reference model
    // ========================================
    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int magnitude(logic [15:0] half);
        int v;
        v = $signed(half);
        return (v < 0) ? -v : v;
    endfunction

    function automatic int expected_level(int base);
        int sum;
        sum = 0;
        for (int i = 0; i < audio_samples; i++) begin
            sum += magnitude(ram_model[base + i][15:0]);
        end
        return sum;
    endfunction

    function automatic int expected_peak(int base);
        int peak;
        int m;
        peak = 0;
        for (int i = 0; i < motion_samples; i++) begin
            m = magnitude(ram_model[base + i][15:0]) + magnitude(ram_model[base + i][31:16]);
            if (m > peak) begin
                peak = m;
            end
        end
        return peak;
    endfunction

    task automatic report_mismatch(input string name, input string what,
                                   input logic [31:0] exp, input logic [31:0] act);
        $display("error %s %s: expected 0x%08h, actual 0x%08h", name, what, exp, act);
        errors++;
    endtask

    // ========================================
    // Bus tasks, called right after a rising edge
    // ========================================
    task automatic write_reg(input logic [3:0] idx, input logic [31:0] data);
        s_axi_awaddr  <= {idx, 2'b00};
        s_axi_wdata   <= data;
        s_axi_awvalid <= 1'b1;
        s_axi_wvalid  <= 1'b1;
        @(posedge clk);
        while (!s_axi_awready && !s_axi_wready) @(posedge clk);
        // Address and data ready pulse together
        if (s_axi_wready !== s_axi_awready) begin
            report_mismatch(current_test, "wready", 32'(s_axi_awready), 32'(s_axi_wready));
        end
        s_axi_awvalid <= 1'b0;
        s_axi_wvalid  <= 1'b0;
        @(posedge clk);
        while (!s_axi_bvalid) @(posedge clk);
    endtask

    task automatic read_reg(input logic [3:0] idx, output logic [31:0] data);
        s_axi_araddr  <= {idx, 2'b00};
        s_axi_arvalid <= 1'b1;
        @(posedge clk);
        while (!s_axi_arready) @(posedge clk);
        s_axi_arvalid <= 1'b0;
        @(posedge clk);
        while (!s_axi_rvalid) @(posedge clk);
        data = s_axi_rdata;
    endtask

    task automatic load_ram();
        logic [31:0] state;
        state = 32;
        for (int i = 0; i < load_words; i++) begin
            state = xorshift32(state);
            ram_model[i] = state;
            write_reg(reg_mem_addr, 32'(i));
            write_reg(reg_mem_wdata, state);
        end
    endtask

    task automatic check_registers(input string name);
        logic [31:0] rd;
        write_reg(reg_audio_base, 32'h0000_0124);
        write_reg(reg_motion_base, 32'h0000_0ff8);
        write_reg(reg_mem_addr, 32'h0000_0155);
        write_reg(reg_status, 32'h0000_0003);
        read_reg(reg_audio_base, rd);
        if (rd !== 32'h0000_0124) report_mismatch(name, "audio_base", 32'h0000_0124, rd);
        read_reg(reg_motion_base, rd);
        if (rd !== 32'h0000_0ff8) report_mismatch(name, "motion_base", 32'h0000_0ff8, rd);
        read_reg(reg_mem_addr, rd);
        if (rd !== 32'h0000_0155) report_mismatch(name, "mem_addr", 32'h0000_0155, rd);
        read_reg(reg_mem_wdata, rd);
        if (rd !== 32'h0) report_mismatch(name, "mem_wdata", 32'h0, rd);
        read_reg(4'd9, rd);
        if (rd !== 32'h0) report_mismatch(name, "index 9", 32'h0, rd);
        read_reg(4'd15, rd);
        if (rd !== 32'h0) report_mismatch(name, "index 15", 32'h0, rd);
        read_reg(reg_status, rd);
        if (rd !== 32'h0) report_mismatch(name, "status", 32'h0, rd);
    endtask

    // Program bases, enable, poll status and compare results
    task automatic run_paths(input string name, input int audio_base, input int motion_base,
                             input logic [1:0] mask);
        logic [31:0] rd;
        write_reg(reg_audio_base, 32'(audio_base * 4));
        write_reg(reg_motion_base, 32'(motion_base * 4));
        write_reg(reg_control, 32'(mask));
        read_reg(reg_status, rd);
        while ((rd[1:0] & mask) != mask) read_reg(reg_status, rd);
        if (rd !== 32'(mask)) report_mismatch(name, "status", 32'(mask), rd);
        if (irq !== 1'b1) report_mismatch(name, "irq", 32'h1, 32'(irq));
        if (mask[bit_audio]) begin
            read_reg(reg_audio_result, rd);
            if (rd !== 32'(expected_level(audio_base))) begin
                report_mismatch(name, "audio_result", 32'(expected_level(audio_base)), rd);
            end
        end
        if (mask[bit_motion]) begin
            read_reg(reg_motion_result, rd);
            if (rd !== 32'(expected_peak(motion_base))) begin
                report_mismatch(name, "motion_result", 32'(expected_peak(motion_base)), rd);
            end
        end
    endtask

    task automatic rerun_paths(input test_row_t row);
        logic [31:0] rd;
        int          motion_first;
        int          motion_second;
        // Region with the lower peak runs second
        if (expected_peak(row.motion_base + rerun_offset) < expected_peak(row.motion_base)) begin
            motion_first  = row.motion_base;
            motion_second = row.motion_base + rerun_offset;
        end else begin
            motion_first  = row.motion_base + rerun_offset;
            motion_second = row.motion_base;
        end
        run_paths(row.name, row.audio_base, motion_first, row.mask);
        repeat (10) @(posedge clk);
        read_reg(reg_status, rd);
        if (rd !== 32'(row.mask)) report_mismatch(row.name, "held status", 32'(row.mask), rd);
        write_reg(reg_control, 32'h0);
        read_reg(reg_status, rd);
        if (rd !== 32'h0) report_mismatch(row.name, "cleared status", 32'h0, rd);
        if (irq !== 1'b0) report_mismatch(row.name, "cleared irq", 32'h0, 32'(irq));
        run_paths(row.name, row.audio_base + rerun_offset, motion_second, row.mask);
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        int errors_before;
        clk           = 1'b0;
        rst_n         = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b1;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b1;
        errors        = 0;
        failed_tests  = 0;
        current_test  = "ram_load";
        tests[0] = '{"reg_access", 0, 0, 2'b00, k_regs};
        tests[1] = '{"audio_only", 0, 0, 2'b01, k_run};
        tests[2] = '{"motion_only", 0, 20, 2'b10, k_run};
        tests[3] = '{"both_paths", 8, 40, 2'b11, k_run};
        tests[4] = '{"done_rerun", 4, 30, 2'b11, k_rerun};
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        load_ram();
        for (int t = 0; t < num_tests; t++) begin
            errors_before = errors;
            current_test  = tests[t].name;
            case (tests[t].kind)
                k_regs:  check_registers(tests[t].name);
                k_run:   run_paths(tests[t].name, tests[t].audio_base, tests[t].motion_base,
                                   tests[t].mask);
                default: rerun_paths(tests[t]);
            endcase
            if (tests[t].kind != k_regs) begin
                write_reg(reg_control, 32'h0);
            end
            if (errors == errors_before) begin
                $display("%s: ok", tests[t].name);
            end else begin
                $display("%s: %0d mismatches", tests[t].name, errors - errors_before);
                failed_tests++;
            end
        end
        $display("tests run %0d, tests failing %0d, mismatches %0d",
                 num_tests, failed_tests, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", watchdog_cycles);
        $display("test failed");
        $finish;
    end

endmodule

// ==== files.f ====
src/regmap_pkg.sv
src/sample_pkg.sv
src/mem_port_if.sv
src/host_regs.sv
src/sample_fetcher.sv
src/audio_level_meter.sv
src/motion_peak_detector.sv
src/mem_arbiter_ram.sv
src/sensor_accel_top.sv
tb/sensor_accel_assertions.sv
tb/tb_sensor_accel.sv

// ==== Bender.yml ====
package:
  name: sensor_accel

sources:
  - src/regmap_pkg.sv
  - src/sample_pkg.sv
  - src/mem_port_if.sv
  - src/host_regs.sv
  - src/sample_fetcher.sv
  - src/audio_level_meter.sv
  - src/motion_peak_detector.sv
  - src/mem_arbiter_ram.sv
  - src/sensor_accel_top.sv
  - target: test
    files:
      - tb/sensor_accel_assertions.sv
      - tb/tb_sensor_accel.sv
